/* flist.f */
verilog/spi_pkg.sv
verilog/spi_settings.sv
verilog/spi_engine.sv
verilog/spi_shifter.sv
verilog/spi_master.sv
test/spi_slave_model.sv
test/tb_spi_master.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP = tb_spi_master
FLIST = flist.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* test/tb_spi_master.sv */
// testbench for the spi master, runs directed transfers against a behavioral slave and checks them
`default_nettype none

module tb_spi_master;
    timeunit 1ns;
    timeprecision 1ps;
    import spi_pkg::*;

    localparam int num_sen = 8;
    localparam logic [addr_width-1:0] base = 8'h00;
    // longest any single wait may take, in clock cycles
    localparam int wait_limit = 2000;

    logic clock = 1'b0;
    logic reset;
    logic set_stb;
    logic [addr_width-1:0] set_addr;
    logic [word_width-1:0] set_data;
    logic miso;
    logic [word_width-1:0] readback;
    logic readback_stb;
    logic ready;
    logic [num_sen-1:0] sen;
    logic sclk;
    logic mosi;

    // slave model side
    logic arm;
    logic [31:0] reply;
    logic sample_rise;
    logic launch_rise;
    logic [31:0] slave_rx;
    int edge_count;

    int errors = 0;
    integer seed = 32'h131aae19;

    // 100 ns period
    always #50 clock = ~clock;

    spi_master #(
        .base_addr(base),
        .num_sen(num_sen),
        .clk_idle(1'b0),
        .sen_idle(24'h0000ff)
    ) u_spi_master (
        .clock(clock),
        .reset(reset),
        .set_stb(set_stb),
        .set_addr(set_addr),
        .set_data(set_data),
        .readback(readback),
        .readback_stb(readback_stb),
        .ready(ready),
        .sen(sen),
        .sclk(sclk),
        .mosi(mosi),
        .miso(miso)
    );

    spi_slave_model #(
        .num_sen(num_sen)
    ) u_slave (
        .arm(arm),
        .reply(reply),
        .sample_rise(sample_rise),
        .launch_rise(launch_rise),
        .sclk(sclk),
        .sen(sen),
        .mosi(mosi),
        .miso(miso),
        .rx_bits(slave_rx),
        .edge_count(edge_count)
    );

    task automatic check_word(input string name, input logic [word_width-1:0] actual,
                              input logic [word_width-1:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic check_sen(input string name, input logic [num_sen-1:0] actual,
                             input logic [num_sen-1:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // all stimulus and sampling happens 1 ns after the rising edge
    task automatic next_cycle;
        @(posedge clock);
        #1;
    endtask

    task automatic bus_write(input logic [addr_width-1:0] addr,
                             input logic [word_width-1:0] data);
        set_stb = 1'b1;
        set_addr = addr;
        set_data = data;
        next_cycle();
        set_stb = 1'b0;
    endtask

    // first n transmitted bits, msb first, collected at the bottom of a word
    function automatic logic [31:0] top_bits(input logic [31:0] word, input int n);
        return word >> (32 - n);
    endfunction

    function automatic logic [31:0] low_mask(input int n);
        logic [63:0] m;
        m = (64'd1 << n) - 64'd1;
        return m[31:0];
    endfunction

    task automatic configure(input int div, input logic [7:0] sel, input int n,
                             input logic din, input logic dout);
        set_word_u word;
        word.raw = '0;
        word.cfg.slave_select = {16'h0000, sel};
        word.cfg.num_bits = n[count_width-1:0];
        word.cfg.datain_edge = din;
        word.cfg.dataout_edge = dout;
        bus_write(base + addr_divider, div);
        bus_write(base + addr_config, word.raw);
        // slave works on the edges the master leaves free
        sample_rise = ~dout;
        launch_rise = ~din;
    endtask

    task automatic start_transfer(input logic [31:0] tx, input logic [31:0] rep);
        check_bit("ready", ready, 1'b1);
        reply = rep;
        arm = 1'b1;
        next_cycle();
        arm = 1'b0;
        bus_write(base + addr_data, tx);
    endtask

    task automatic wait_done;
        int count;
        count = 0;
        while (!readback_stb && count < wait_limit) begin
            next_cycle();
            count++;
        end
        if (!readback_stb) begin
            errors++;
            $display("timeout at %0t ns: readback_stb never arrived", $time);
        end else begin
            // ready returns together with a one-cycle strobe
            check_bit("ready at readback_stb", ready, 1'b1);
            next_cycle();
            check_bit("readback_stb one cycle later", readback_stb, 1'b0);
        end
    endtask

    task automatic run_and_check(input logic [31:0] tx, input logic [31:0] rep, input int n);
        start_transfer(tx, rep);
        wait_done();
        check_word("slave mosi bits", slave_rx, top_bits(tx, n));
        check_word("readback", readback & low_mask(n), top_bits(rep, n));
    endtask

    task automatic check_reset_state;
        int count;
        check_bit("sclk", sclk, 1'b0);
        check_sen("sen", sen, 8'hff);
        check_bit("readback_stb after reset", readback_stb, 1'b0);
        check_bit("ready in reset", ready, 1'b0);
        count = 0;
        while (!ready && count < 4) begin
            next_cycle();
            count++;
        end
        check_bit("ready after reset", ready, 1'b1);
    endtask

    // sample on rising, launch on falling
    task automatic transfer_8bit;
        logic [31:0] tx;
        logic [31:0] rep;
        tx = $random(seed);
        rep = $random(seed);
        configure(2, 8'h01, 8, 1'b1, 1'b0);
        run_and_check(tx, rep, 8);
    endtask

    task automatic edge_modes;
        logic [31:0] tx;
        logic [31:0] rep;
        for (int mode = 0; mode < 4; mode++) begin
            tx = $random(seed);
            rep = $random(seed);
            configure(2, 8'h01, 32, mode[1], mode[0]);
            run_and_check(tx, rep, 32);
        end
    endtask

    task automatic select_pattern;
        int count;
        configure(2, 8'h05, 6, 1'b1, 1'b0);
        start_transfer($random(seed), $random(seed));
        count = 0;
        while (!sclk && count < wait_limit) begin
            next_cycle();
            count++;
        end
        if (!sclk) begin
            errors++;
            $display("timeout at %0t ns: sclk never left its idle level", $time);
        end
        check_sen("sen during transfer", sen, 8'hfa);
        wait_done();
        check_sen("sen after transfer", sen, 8'hff);
        check_word("sclk edge count", edge_count, 32'd12);
    endtask

    task automatic divider_spacing;
        int gap;
        int toggles;
        int count;
        logic last_sclk;
        configure(4, 8'h01, 4, 1'b1, 1'b0);
        start_transfer(32'hc3000000, 32'h90000000);
        gap = 0;
        toggles = 0;
        count = 0;
        last_sclk = sclk;
        while (!readback_stb && count < wait_limit) begin
            next_cycle();
            count++;
            gap++;
            if (sclk !== last_sclk) begin
                // one half period is divider+1 cycles
                if (toggles > 0) begin
                    check_word("sclk spacing", gap, 32'd5);
                end
                toggles++;
                gap = 0;
                last_sclk = sclk;
            end
        end
        if (!readback_stb) begin
            errors++;
            $display("timeout at %0t ns: transfer with divider 4 never finished", $time);
        end
        check_word("sclk toggles", toggles, 32'd8);
        check_word("slave mosi bits", slave_rx, 32'h0000000c);
    endtask

    task automatic shutdown_hold;
        logic moved;
        bus_write(base + addr_shutdown, 32'd1);
        check_bit("ready in shutdown", ready, 1'b0);
        configure(2, 8'h01, 8, 1'b1, 1'b0);
        bus_write(base + addr_data, 32'h5a5a5a5a);
        moved = 1'b0;
        // the full window must stay quiet
        for (int count = 0; count < 40; count++) begin
            next_cycle();
            if (sclk !== 1'b0 || sen !== 8'hff) begin
                moved = 1'b1;
            end
        end
        check_bit("sclk activity in shutdown", moved, 1'b0);
        check_bit("ready in shutdown", ready, 1'b0);
        bus_write(base + addr_shutdown, 32'd0);
        run_and_check($random(seed), $random(seed), 8);
    endtask

    initial begin
        reset = 1'b1;
        set_stb = 1'b0;
        set_addr = '0;
        set_data = '0;
        arm = 1'b0;
        reply = '0;
        sample_rise = 1'b1;
        launch_rise = 1'b0;
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;
        check_reset_state();
        transfer_8bit();
        edge_modes();
        select_pattern();
        divider_spacing();
        shutdown_hold();
        $display("run complete, errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/spi_slave_model.sv */
// behavioral spi slave for the testbench, captures mosi and answers with a preset word on miso
`default_nettype none

module spi_slave_model #(
    parameter int num_sen = 8
) (
    input  logic               arm,
    input  logic [31:0]        reply,
    input  logic               sample_rise,
    input  logic               launch_rise,
    input  logic               sclk,
    input  logic [num_sen-1:0] sen,
    input  logic               mosi,
    output logic               miso,
    output logic [31:0]        rx_bits,
    output int                 edge_count
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] tx_bits = '0;
    int rise_count = 0;
    logic selected;

    // addressed while any select line is low
    assign selected = ~&sen;
    // reply leaves msb first
    assign miso = tx_bits[31];

    initial begin
        rx_bits = '0;
        edge_count = 0;
    end

    always @(posedge arm or posedge sclk or negedge sclk) begin
        if (arm) begin
            // fresh reply and empty capture before each transfer
            tx_bits = reply;
            rx_bits = '0;
            edge_count = 0;
            rise_count = 0;
        end else if (selected) begin
            edge_count = edge_count + 1;
            if (sclk) begin
                rise_count = rise_count + 1;
                if (sample_rise) begin
                    rx_bits = {rx_bits[30:0], mosi};
                end
                // msb is already out, the first rising edge leaves it there
                if (launch_rise && rise_count > 1) begin
                    tx_bits = {tx_bits[30:0], 1'b0};
                end
            end else begin
                if (!sample_rise) begin
                    rx_bits = {rx_bits[30:0], mosi};
                end
                // falling launch, msb was preset so every edge moves on
                if (!launch_rise) begin
                    tx_bits = {tx_bits[30:0], 1'b0};
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/spi_master.sv */
// top level of the settings-bus spi master, ties the register block, sequencer and data path
`default_nettype none

module spi_master #(
    parameter logic [spi_pkg::addr_width-1:0]  base_addr = 8'h00,
    parameter int                              num_sen = 8,
    parameter logic                            clk_idle = 1'b0,
    parameter logic [spi_pkg::sel_width-1:0]   sen_idle = 24'hffffff
) (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               set_stb,
    input  logic [spi_pkg::addr_width-1:0]     set_addr,
    input  logic [spi_pkg::word_width-1:0]     set_data,
    output logic [spi_pkg::word_width-1:0]     readback,
    output logic                               readback_stb,
    output logic                               ready,
    output logic [num_sen-1:0]                 sen,
    output logic                               sclk,
    output logic                               mosi,
    input  logic                               miso
);
    import spi_pkg::*;

    // settings levels
    logic [divider_width-1:0] sclk_divider;
    logic [sel_width-1:0] slave_select;
    logic [count_width-1:0] num_bits;
    logic datain_edge;
    logic dataout_edge;
    logic [word_width-1:0] mosi_word;
    logic shutdown;
    logic start;

    // engine to data path commands
    logic load;
    logic shift_out;
    logic shift_in;

    spi_settings #(
        .base_addr(base_addr)
    ) u_settings (
        .clock(clock),
        .reset(reset),
        .set_stb(set_stb),
        .set_addr(set_addr),
        .set_data(set_data),
        .sclk_divider(sclk_divider),
        .slave_select(slave_select),
        .num_bits(num_bits),
        .datain_edge(datain_edge),
        .dataout_edge(dataout_edge),
        .mosi_word(mosi_word),
        .shutdown(shutdown),
        .start(start)
    );

    spi_engine #(
        .num_sen(num_sen),
        .clk_idle(clk_idle),
        .sen_idle(sen_idle)
    ) u_engine (
        .clock(clock),
        .reset(reset),
        .start(start),
        .shutdown(shutdown),
        .sclk_divider(sclk_divider),
        .slave_select(slave_select),
        .num_bits(num_bits),
        .datain_edge(datain_edge),
        .dataout_edge(dataout_edge),
        .sclk(sclk),
        .sen(sen),
        .ready(ready),
        .readback_stb(readback_stb),
        .load(load),
        .shift_out(shift_out),
        .shift_in(shift_in)
    );

    spi_shifter u_shifter (
        .clock(clock),
        .reset(reset),
        .load(load),
        .shift_out(shift_out),
        .shift_in(shift_in),
        .mosi_word(mosi_word),
        .miso(miso),
        .mosi(mosi),
        .rx_word(readback)
    );

endmodule

`default_nettype wire

/* verilog/spi_shifter.sv */
// data path of the spi master, transmit and receive shift registers with i/o retiming flops
`default_nettype none

module spi_shifter (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            load,
    input  logic                            shift_out,
    input  logic                            shift_in,
    input  logic [spi_pkg::word_width-1:0]  mosi_word,
    input  logic                            miso,
    output logic                            mosi,
    output logic [spi_pkg::word_width-1:0]  rx_word
);
    import spi_pkg::*;

    logic [word_width-1:0] tx_reg;
    logic [word_width-1:0] rx_reg;
    logic miso_stage1;
    logic miso_stage2;

    // transmit register, msb first so it moves left
    always_ff @(posedge clock) begin
        if (load) begin
            tx_reg <= mosi_word;
        end else if (shift_out) begin
            tx_reg <= {tx_reg[word_width-2:0], 1'b0};
        end
    end

    // output flop next to the pad, mosi is one cycle behind tx_reg
    always_ff @(posedge clock) begin
        if (reset) begin
            mosi <= 1'b0;
        end else begin
            mosi <= tx_reg[word_width-1];
        end
    end

    // two input flops on miso, the engine samples data two cycles old
    always_ff @(posedge clock) begin
        miso_stage1 <= miso;
        miso_stage2 <= miso_stage1;
    end

    // receive register, new bits enter at bit 0
    // after n bits the reply sits in the low n bits in arrival order
    always_ff @(posedge clock) begin
        if (reset) begin
            rx_reg <= '0;
        end else if (shift_in) begin
            rx_reg <= {rx_reg[word_width-2:0], miso_stage2};
        end
    end

    // readback word, held between transfers
    assign rx_word = rx_reg;

endmodule

`default_nettype wire

/* verilog/spi_engine.sv */
// serial clock sequencer of the spi master, drives sclk and sen and commands the shift registers
`default_nettype none

module spi_engine #(
    parameter int                              num_sen = 8,
    parameter logic                            clk_idle = 1'b0,
    parameter logic [spi_pkg::sel_width-1:0]   sen_idle = 24'hffffff
) (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               start,
    input  logic                               shutdown,
    input  logic [spi_pkg::divider_width-1:0]  sclk_divider,
    input  logic [spi_pkg::sel_width-1:0]      slave_select,
    input  logic [spi_pkg::count_width-1:0]    num_bits,
    input  logic                               datain_edge,
    input  logic                               dataout_edge,
    output logic                               sclk,
    output logic [num_sen-1:0]                 sen,
    output logic                               ready,
    output logic                               readback_stb,
    output logic                               load,
    output logic                               shift_out,
    output logic                               shift_in
);
    import spi_pkg::*;

    engine_state_t state;
    logic ready_reg;
    logic sclk_reg;
    logic trigger;

    logic [divider_width-1:0] sclk_counter;
    logic [divider_width-1:0] sclk_counter_next;
    logic sclk_counter_done;

    logic [count_width-1:0] bit_counter;
    logic [count_width-1:0] bit_counter_next;
    logic bit_counter_done;

    logic sen_is_idle;
    logic [sel_width-1:0] sen_next;
    logic [num_sen-1:0] sen_reg;

    // shutdown swallows any trigger
    assign trigger = start & ~shutdown;
    // drops in the same cycle as start so the host sees busy right away
    assign ready = ready_reg & ~start & ~shutdown;
    assign sclk = sclk_reg;
    assign sen = sen_reg;

    // divider tick, one half period is sclk_divider+1 cycles
    assign sclk_counter_done = (sclk_counter == sclk_divider);
    assign sclk_counter_next = sclk_counter_done ? '0 : sclk_counter + 1'b1;

    // bit count advances once per full sclk period
    assign bit_counter_next = bit_counter + 1'b1;
    assign bit_counter_done = (bit_counter_next == num_bits);

    // transmit register takes the new word as the transfer is accepted
    assign load = (state == wait_trig) & trigger;

    // shift commands land on the same edge that toggles sclk
    always_comb begin
        shift_in = 1'b0;
        shift_out = 1'b0;
        if (sclk_counter_done) begin
            if (state == clk_reg) begin
                // leaving the idle level
                shift_in = (datain_edge != clk_idle);
                // first launch skipped, msb is already on mosi
                shift_out = (dataout_edge != clk_idle) && (bit_counter != '0);
            end else if (state == clk_inv) begin
                // returning to the idle level
                shift_in = (datain_edge == clk_idle);
                // no launch after the last bit
                shift_out = (dataout_edge == clk_idle) && !bit_counter_done;
            end
        end
    end

    // slave selects inactive in wait_trig and idle_sen
    assign sen_is_idle = (state == wait_trig) || (state == idle_sen);
    assign sen_next = sen_is_idle ? sen_idle : (sen_idle ^ slave_select);

    // extra flop ahead of the pads, sen trails the state by a cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            sen_reg <= sen_idle[num_sen-1:0];
        end else begin
            sen_reg <= sen_next[num_sen-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= wait_trig;
            sclk_reg <= clk_idle;
            ready_reg <= 1'b0;
            readback_stb <= 1'b0;
            sclk_counter <= '0;
            bit_counter <= '0;
        end else begin
            case (state)
                wait_trig: begin
                    if (trigger) begin
                        state <= pre_idle;
                    end
                    readback_stb <= 1'b0;
                    ready_reg <= ~start;
                    sclk_counter <= '0;
                    bit_counter <= '0;
                    sclk_reg <= clk_idle;
                end
                pre_idle: begin
                    // selects settle for one half period before the first edge
                    if (sclk_counter_done) begin
                        state <= clk_reg;
                    end
                    sclk_counter <= sclk_counter_next;
                    sclk_reg <= clk_idle;
                end
                clk_reg: begin
                    if (sclk_counter_done) begin
                        state <= clk_inv;
                        sclk_reg <= ~clk_idle;
                    end
                    sclk_counter <= sclk_counter_next;
                end
                clk_inv: begin
                    if (sclk_counter_done) begin
                        state <= bit_counter_done ? post_idle : clk_reg;
                        bit_counter <= bit_counter_next;
                        sclk_reg <= clk_idle;
                    end
                    sclk_counter <= sclk_counter_next;
                end
                post_idle: begin
                    // hold time after the last edge, selects still active
                    if (sclk_counter_done) begin
                        state <= idle_sen;
                    end
                    sclk_counter <= sclk_counter_next;
                    sclk_reg <= clk_idle;
                end
                idle_sen: begin
                    // selects released, one more half period then report done
                    if (sclk_counter_done) begin
                        state <= wait_trig;
                        ready_reg <= 1'b1;
                        readback_stb <= 1'b1;
                    end
                    sclk_counter <= sclk_counter_next;
                    sclk_reg <= clk_idle;
                end
                default: begin
                    state <= wait_trig;
                end
            endcase
        end
    end

    // with a slave addressed, sclk only moves while its select is asserted
    a_sclk_parked: assert property (
        @(posedge clock) disable iff (reset)
        (sen == sen_idle[num_sen-1:0]) && (slave_select[num_sen-1:0] != '0)
            |-> (sclk == clk_idle)
    ) else $error("sclk toggled with slave selects idle");

    // done strobe is a single cycle pulse
    a_readback_pulse: assert property (
        @(posedge clock) disable iff (reset)
        readback_stb |=> !readback_stb
    ) else $error("readback_stb longer than one cycle");

endmodule

`default_nettype wire

/* verilog/spi_settings.sv */
// settings register block of the spi master, decodes host bus writes into engine controls
`default_nettype none

module spi_settings #(
    parameter logic [spi_pkg::addr_width-1:0] base_addr = 8'h00
) (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               set_stb,
    input  logic [spi_pkg::addr_width-1:0]     set_addr,
    input  logic [spi_pkg::word_width-1:0]     set_data,
    output logic [spi_pkg::divider_width-1:0]  sclk_divider,
    output logic [spi_pkg::sel_width-1:0]      slave_select,
    output logic [spi_pkg::count_width-1:0]    num_bits,
    output logic                               datain_edge,
    output logic                               dataout_edge,
    output logic [spi_pkg::word_width-1:0]     mosi_word,
    output logic                               shutdown,
    output logic                               start
);
    import spi_pkg::*;

    // absolute addresses, wrap within the 8 bit space
    localparam logic [addr_width-1:0] divider_sel = base_addr + addr_divider;
    localparam logic [addr_width-1:0] config_sel = base_addr + addr_config;
    localparam logic [addr_width-1:0] data_sel = base_addr + addr_data;
    localparam logic [addr_width-1:0] shutdown_sel = base_addr + addr_shutdown;

    set_word_u set_word;
    logic wr_divider;
    logic wr_config;
    logic wr_data;
    logic wr_shutdown;

    // same bus word, read through whichever view the target register needs
    assign set_word.raw = set_data;

    // one write enable per register
    assign wr_divider = set_stb && (set_addr == divider_sel);
    assign wr_config = set_stb && (set_addr == config_sel);
    assign wr_data = set_stb && (set_addr == data_sel);
    assign wr_shutdown = set_stb && (set_addr == shutdown_sel);

    always_ff @(posedge clock) begin
        if (reset) begin
            sclk_divider <= '0;
            slave_select <= '0;
            num_bits <= '0;
            datain_edge <= 1'b0;
            dataout_edge <= 1'b0;
            mosi_word <= '0;
            shutdown <= 1'b0;
            start <= 1'b0;
        end else begin
            // a data write kicks off a transfer in the following cycle
            start <= wr_data;

            // half period length in clock cycles minus one
            if (wr_divider) begin
                sclk_divider <= set_word.raw[divider_width-1:0];
            end

            // config word unpacked into its fields
            if (wr_config) begin
                slave_select <= set_word.cfg.slave_select;
                num_bits <= set_word.cfg.num_bits;
                datain_edge <= set_word.cfg.datain_edge;
                dataout_edge <= set_word.cfg.dataout_edge;
            end

            // transmit word, msb leaves first
            if (wr_data) begin
                mosi_word <= set_word.raw;
            end

            // only bit 0 matters for shutdown
            if (wr_shutdown) begin
                shutdown <= set_word.raw[0];
            end
        end
    end

    // engine expects a single cycle trigger per data write
    a_start_pulse: assert property (
        @(posedge clock) disable iff (reset)
        start |=> !start
    ) else $error("start held high for more than one cycle");

endmodule

`default_nettype wire

/* verilog/spi_pkg.sv */
// shared register map, field widths and types for the spi master, imported by every rtl block
`default_nettype none

package spi_pkg;

    // settings bus geometry
    localparam int addr_width = 8;
    localparam int word_width = 32;

    // widths of the individual settings fields
    localparam int divider_width = 16;
    localparam int sel_width = 24;
    localparam int count_width = 6;

    // register offsets from the settings base address
    localparam logic [addr_width-1:0] addr_divider = 8'd0;
    localparam logic [addr_width-1:0] addr_config = 8'd1;
    localparam logic [addr_width-1:0] addr_data = 8'd2;
    localparam logic [addr_width-1:0] addr_shutdown = 8'd3;

    // configuration register layout, msb first
    // dataout_edge at bit 31, datain_edge at bit 30, num_bits at 29:24
    typedef struct packed {
        // 1 launches transmit bits on the rising sclk edge
        logic dataout_edge;
        // 1 samples receive bits on the rising sclk edge
        logic datain_edge;
        // transfer length, 1 through 32
        logic [count_width-1:0] num_bits;
        // one bit per slave, a 1 selects that slave
        logic [sel_width-1:0] slave_select;
    } spi_config_t;

    // a settings data word seen either as config fields or as a plain value
    typedef union packed {
        spi_config_t cfg;
        logic [word_width-1:0] raw;
    } set_word_u;

    // serial clock sequencer states
    typedef enum logic [2:0] {
        wait_trig,
        pre_idle,
        clk_reg,
        clk_inv,
        post_idle,
        idle_sen
    } engine_state_t;

endpackage

`default_nettype wire
